// ==== logic/sopc_pkg.sv ====
`default_nettype none

package sopc_pkg;

    // ##########################################################
    // Bus payloads
    // ##########################################################

    typedef struct packed {
        logic        wr;    // Write when set.
        logic [31:0] addr;  // Byte address.
        logic [31:0] wdata;
        logic [3:0]  strb;  // Byte lanes for writes.
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;   // Decode error.
    } bus_rsp_t;

    // ##########################################################
    // Address map
    // ##########################################################

    localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
    localparam logic [31:0] GPIO_BASE   = 32'h1000_0000;
    localparam logic [31:0] REGION_MASK = 32'hF000_0000; // Upper nibble picks the slave.

    localparam logic [3:0] GPIO_PIO_OFFSET = 4'h0;
    localparam logic [3:0] GPIO_KEY_OFFSET = 4'h4;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_NONE
    } slave_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESP
    } ram_state_e;

endpackage

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ibus_req_valid_i,
    input  sopc_pkg::bus_req_t ibus_req_i,
    input  logic               dbus_req_valid_i,
    input  sopc_pkg::bus_req_t dbus_req_i,
    input  logic               rsp_valid_i,
    input  sopc_pkg::bus_rsp_t rsp_i,
    output logic               ibus_req_ready_o,
    output logic               dbus_req_ready_o,
    output logic               ibus_rsp_valid_o,
    output sopc_pkg::bus_rsp_t ibus_rsp_o,
    output logic               dbus_rsp_valid_o,
    output sopc_pkg::bus_rsp_t dbus_rsp_o,
    output logic               req_valid_o,
    output sopc_pkg::bus_req_t req_o
);

    logic               busy_q;
    logic               owner_dbus_q;   // Who gets the response.
    logic               prio_dbus_q;    // Round-robin pointer.
    logic               grant_dbus;
    logic               accept;
    logic               req_valid_q;
    logic               rsp_valid_q;
    sopc_pkg::bus_req_t req_q;
    sopc_pkg::bus_rsp_t rsp_q;

    always_comb begin
        if (ibus_req_valid_i && dbus_req_valid_i) begin
            grant_dbus = prio_dbus_q;   // Both asking.
        end else begin
            grant_dbus = dbus_req_valid_i;
        end
    end

    assign ibus_req_ready_o = !busy_q && ibus_req_valid_i && !grant_dbus;
    assign dbus_req_ready_o = !busy_q && dbus_req_valid_i && grant_dbus;
    assign accept           = ibus_req_ready_o || dbus_req_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            owner_dbus_q <= 1'b0;
            prio_dbus_q  <= 1'b0;       // Instruction bus first.
            req_valid_q  <= 1'b0;
            rsp_valid_q  <= 1'b0;
        end else begin
            req_valid_q <= accept;
            rsp_valid_q <= rsp_valid_i;
            if (accept) begin
                busy_q       <= 1'b1;
                owner_dbus_q <= grant_dbus;
                prio_dbus_q  <= !grant_dbus;
            end else if (rsp_valid_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= grant_dbus ? dbus_req_i : ibus_req_i;
        end
        if (rsp_valid_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign req_valid_o      = req_valid_q;
    assign req_o            = req_q;
    assign ibus_rsp_valid_o = rsp_valid_q && !owner_dbus_q;
    assign dbus_rsp_valid_o = rsp_valid_q && owner_dbus_q;
    assign ibus_rsp_o       = rsp_q;
    assign dbus_rsp_o       = rsp_q;

    a_single_ready: assert property (@(posedge clk) disable iff (reset_i)
        !(ibus_req_ready_o && dbus_req_ready_o));

    // A response from the slaves must belong to a transfer we issued.
    a_rsp_when_busy: assert property (@(posedge clk) disable iff (reset_i)
        rsp_valid_i |-> busy_q);

endmodule

`default_nettype wire

// ==== logic/slave_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module slave_decoder (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               req_valid_i,
    input  sopc_pkg::bus_req_t req_i,
    input  logic               ram_done_i,
    input  sopc_pkg::bus_rsp_t ram_rsp_i,
    input  logic               gpio_done_i,
    input  sopc_pkg::bus_rsp_t gpio_rsp_i,
    output logic               ram_req_valid_o,
    output logic               gpio_req_valid_o,
    output sopc_pkg::bus_req_t slave_req_o,
    output logic               rsp_valid_o,
    output sopc_pkg::bus_rsp_t rsp_o
);

    sopc_pkg::slave_sel_e sel_d;
    sopc_pkg::slave_sel_e sel_q;
    logic                 pend_q;   // Waiting for a done.
    logic                 err_q;

    always_comb begin
        if ((req_i.addr & sopc_pkg::REGION_MASK) == sopc_pkg::RAM_BASE) begin
            sel_d = sopc_pkg::SEL_RAM;
        end else if ((req_i.addr & sopc_pkg::REGION_MASK) == sopc_pkg::GPIO_BASE) begin
            sel_d = sopc_pkg::SEL_GPIO;
        end else begin
            sel_d = sopc_pkg::SEL_NONE;
        end
    end

    assign ram_req_valid_o  = req_valid_i && (sel_d == sopc_pkg::SEL_RAM);
    assign gpio_req_valid_o = req_valid_i && (sel_d == sopc_pkg::SEL_GPIO);

    // Slaves see the offset inside their region.
    always_comb begin
        slave_req_o      = req_i;
        slave_req_o.addr = req_i.addr & ~sopc_pkg::REGION_MASK;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_q  <= sopc_pkg::SEL_NONE;
            pend_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            err_q <= req_valid_i && (sel_d == sopc_pkg::SEL_NONE);
            if (req_valid_i) begin
                sel_q  <= sel_d;
                pend_q <= 1'b1;
            end else if (rsp_valid_o) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rsp_valid_o = 1'b0;
        rsp_o       = '{rdata: 32'h0, err: 1'b1}; // Error answer.
        if (pend_q) begin
            case (sel_q)
                sopc_pkg::SEL_RAM: begin
                    rsp_valid_o = ram_done_i;
                    rsp_o       = ram_rsp_i;
                end
                sopc_pkg::SEL_GPIO: begin
                    rsp_valid_o = gpio_done_i;
                    rsp_o       = gpio_rsp_i;
                end
                default: begin
                    rsp_valid_o = err_q;
                end
            endcase
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset_i)
        !(ram_req_valid_o && gpio_req_valid_o));

    a_no_overlap: assert property (@(posedge clk) disable iff (reset_i)
        req_valid_i |-> !pend_q);

endmodule

`default_nettype wire

// ==== logic/ram_bridge.sv ====
`default_nettype none
`timescale 1ns/1ps

module ram_bridge #(
    parameter int RAM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_valid_i,
    input  sopc_pkg::bus_req_t    req_i,
    input  logic [31:0]           ram_rdata_i,
    input  logic                  ram_accept_i,
    output logic                  ram_rd_o,
    output logic [3:0]            ram_wr_o,
    output logic [RAM_ADDR_W-1:0] ram_addr_o,
    output logic [31:0]           ram_wdata_o,
    output logic                  done_o,
    output sopc_pkg::bus_rsp_t    rsp_o
);

    sopc_pkg::ram_state_e state_q;
    sopc_pkg::ram_state_e state_d;
    logic                 strobe;
    logic [31:0]          rdata_q;

    // The arbiter holds the request for the whole transfer.
    assign strobe = (state_q == sopc_pkg::ST_IDLE && req_valid_i) ||
                    (state_q == sopc_pkg::ST_ACCESS && !ram_accept_i);

    assign ram_rd_o    = strobe && !req_i.wr;
    assign ram_wr_o    = (strobe && req_i.wr) ? req_i.strb : 4'b0000;
    assign ram_addr_o  = req_i.addr[RAM_ADDR_W+1:2]; // Word address.
    assign ram_wdata_o = req_i.wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sopc_pkg::ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = sopc_pkg::ST_ACCESS;
                end
            end
            sopc_pkg::ST_ACCESS: begin
                if (ram_accept_i) begin
                    state_d = sopc_pkg::ST_RESP;
                end
            end
            default: begin
                state_d = sopc_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= sopc_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == sopc_pkg::ST_ACCESS && ram_accept_i) begin
            rdata_q <= req_i.wr ? 32'h0 : ram_rdata_i; // Writes answer zero.
        end
    end

    assign done_o = (state_q == sopc_pkg::ST_RESP);
    assign rsp_o  = '{rdata: rdata_q, err: 1'b0};

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(ram_rd_o && |ram_wr_o));

endmodule

`default_nettype wire

// ==== logic/sram.sv ====
`default_nettype none
`timescale 1ns/1ps

module sram #(
    parameter int RAM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  rd_i,
    input  logic [3:0]            wr_i,
    input  logic [RAM_ADDR_W-1:0] addr_i,
    input  logic [31:0]           data_i,
    output logic [31:0]           data_o,
    output logic                  accept_o
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [31:0] mem [DEPTH];
    logic [31:0] data_q;
    logic        accept_q;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_i[i]) begin
                mem[addr_i][i*8 +: 8] <= data_i[i*8 +: 8]; // Byte lane.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            data_q <= mem[addr_i];
        end
    end

    // One cycle to take any strobe.
    always_ff @(posedge clk) begin
        accept_q <= rd_i || (|wr_i);
    end

    assign data_o   = data_q;
    assign accept_o = accept_q;

endmodule

`default_nettype wire

// ==== logic/gpio_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpio_regs #(
    parameter int GPIO_W = 4
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               req_valid_i,
    input  sopc_pkg::bus_req_t req_i,
    input  logic [GPIO_W-1:0]  key_i,
    output logic               done_o,
    output sopc_pkg::bus_rsp_t rsp_o,
    output logic [GPIO_W-1:0]  pio_o
);

    logic [GPIO_W-1:0] key_meta_q;
    logic [GPIO_W-1:0] key_sync_q;
    logic [GPIO_W-1:0] pio_q;
    logic              done_q;
    logic [31:0]       rdata_q;
    logic [3:0]        offset;

    assign offset = req_i.addr[3:0];

    // Two-flop synchronizer for the keys.
    always_ff @(posedge clk) begin
        key_meta_q <= key_i;
        key_sync_q <= key_meta_q;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pio_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= req_valid_i;
            if (req_valid_i && req_i.wr && req_i.strb[0] &&
                offset == sopc_pkg::GPIO_PIO_OFFSET) begin
                pio_q <= req_i.wdata[GPIO_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rdata_q <= 32'h0;
            if (!req_i.wr && offset == sopc_pkg::GPIO_PIO_OFFSET) begin
                rdata_q <= 32'(pio_q);
            end else if (!req_i.wr && offset == sopc_pkg::GPIO_KEY_OFFSET) begin
                rdata_q <= 32'(key_sync_q);
            end
        end
    end

    assign done_o = done_q;
    assign rsp_o  = '{rdata: rdata_q, err: 1'b0};
    assign pio_o  = pio_q;

endmodule

`default_nettype wire

// ==== logic/sopc_fabric.sv ====
`default_nettype none
`timescale 1ns/1ps

module sopc_fabric #(
    parameter int RAM_ADDR_W = 12,
    parameter int GPIO_W     = 4
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ibus_req_valid_i,
    input  sopc_pkg::bus_req_t ibus_req_i,
    input  logic               dbus_req_valid_i,
    input  sopc_pkg::bus_req_t dbus_req_i,
    input  logic [GPIO_W-1:0]  key_i,
    output logic               ibus_req_ready_o,
    output logic               ibus_rsp_valid_o,
    output sopc_pkg::bus_rsp_t ibus_rsp_o,
    output logic               dbus_req_ready_o,
    output logic               dbus_rsp_valid_o,
    output sopc_pkg::bus_rsp_t dbus_rsp_o,
    output logic [GPIO_W-1:0]  pio_o
);

    // ##########################################################
    // Fabric
    // ##########################################################

    logic                  arb_req_valid;
    sopc_pkg::bus_req_t    arb_req;
    logic                  dec_rsp_valid;
    sopc_pkg::bus_rsp_t    dec_rsp;
    logic                  ram_req_valid;
    logic                  gpio_req_valid;
    sopc_pkg::bus_req_t    slave_req;
    logic                  ram_done;
    sopc_pkg::bus_rsp_t    ram_rsp;
    logic                  gpio_done;
    sopc_pkg::bus_rsp_t    gpio_rsp;

    logic                  sram_rd;
    logic [3:0]            sram_wr;
    logic [RAM_ADDR_W-1:0] sram_addr;
    logic [31:0]           sram_wdata;
    logic [31:0]           sram_rdata;
    logic                  sram_accept;

    bus_arbiter u_arbiter (
        .clk                (clk                ),
        .reset_i            (reset_i            ),
        .ibus_req_valid_i   (ibus_req_valid_i   ),
        .ibus_req_i         (ibus_req_i         ),
        .dbus_req_valid_i   (dbus_req_valid_i   ),
        .dbus_req_i         (dbus_req_i         ),
        .rsp_valid_i        (dec_rsp_valid      ),
        .rsp_i              (dec_rsp            ),
        .ibus_req_ready_o   (ibus_req_ready_o   ),
        .dbus_req_ready_o   (dbus_req_ready_o   ),
        .ibus_rsp_valid_o   (ibus_rsp_valid_o   ),
        .ibus_rsp_o         (ibus_rsp_o         ),
        .dbus_rsp_valid_o   (dbus_rsp_valid_o   ),
        .dbus_rsp_o         (dbus_rsp_o         ),
        .req_valid_o        (arb_req_valid      ),
        .req_o              (arb_req            )
    );

    slave_decoder u_decoder (
        .clk                (clk                ),
        .reset_i            (reset_i            ),
        .req_valid_i        (arb_req_valid      ),
        .req_i              (arb_req            ),
        .ram_done_i         (ram_done           ),
        .ram_rsp_i          (ram_rsp            ),
        .gpio_done_i        (gpio_done          ),
        .gpio_rsp_i         (gpio_rsp           ),
        .ram_req_valid_o    (ram_req_valid      ),
        .gpio_req_valid_o   (gpio_req_valid     ),
        .slave_req_o        (slave_req          ),
        .rsp_valid_o        (dec_rsp_valid      ),
        .rsp_o              (dec_rsp            )
    );

    // ##########################################################
    // Slaves
    // ##########################################################

    ram_bridge #(
        .RAM_ADDR_W         (RAM_ADDR_W         )
    ) u_ram_bridge (
        .clk                (clk                ),
        .reset_i            (reset_i            ),
        .req_valid_i        (ram_req_valid      ),
        .req_i              (slave_req          ),
        .ram_rdata_i        (sram_rdata         ),
        .ram_accept_i       (sram_accept        ),
        .ram_rd_o           (sram_rd            ),
        .ram_wr_o           (sram_wr            ),
        .ram_addr_o         (sram_addr          ),
        .ram_wdata_o        (sram_wdata         ),
        .done_o             (ram_done           ),
        .rsp_o              (ram_rsp            )
    );

    sram #(
        .RAM_ADDR_W         (RAM_ADDR_W         )
    ) u_sram (
        .clk                (clk                ),
        .rd_i               (sram_rd            ),
        .wr_i               (sram_wr            ),
        .addr_i             (sram_addr          ),
        .data_i             (sram_wdata         ),
        .data_o             (sram_rdata         ),
        .accept_o           (sram_accept        )
    );

    gpio_regs #(
        .GPIO_W             (GPIO_W             )
    ) u_gpio (
        .clk                (clk                ),
        .reset_i            (reset_i            ),
        .req_valid_i        (gpio_req_valid     ),
        .req_i              (slave_req          ),
        .key_i              (key_i              ),
        .done_o             (gpio_done          ),
        .rsp_o              (gpio_rsp           ),
        .pio_o              (pio_o              )
    );

endmodule

`default_nettype wire

// ==== dv/sopc_model.svh ====
`ifndef SOPC_MODEL_SVH
`define SOPC_MODEL_SVH

// ##########################################################
// Reference model of the address map
// ##########################################################

localparam int RAM_WINDOW_WORDS = 16;   // Words the stimulus touches.

logic [31:0]       ref_mem [RAM_WINDOW_WORDS];
logic [GPIO_W-1:0] ref_pio;

function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
endfunction

// Applies one accepted transfer and returns the response it must get.
function automatic sopc_pkg::bus_rsp_t apply_transfer(
    input sopc_pkg::bus_req_t req,
    input logic [GPIO_W-1:0]  key
);
    sopc_pkg::bus_rsp_t rsp;
    logic [31:0]        region;
    int                 word;
    rsp    = '{rdata: 32'h0, err: 1'b0};
    region = req.addr & sopc_pkg::REGION_MASK;
    word   = int'(req.addr[15:2]) % RAM_WINDOW_WORDS;
    if (region == sopc_pkg::RAM_BASE) begin
        if (req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    ref_mem[word][b*8 +: 8] = req.wdata[b*8 +: 8]; // Lane by lane.
                end
            end
        end else begin
            rsp.rdata = ref_mem[word];
        end
    end else if (region == sopc_pkg::GPIO_BASE) begin
        if (req.wr) begin
            if (req.addr[3:0] == sopc_pkg::GPIO_PIO_OFFSET && req.strb[0]) begin
                ref_pio = req.wdata[GPIO_W-1:0];
            end
        end else if (req.addr[3:0] == sopc_pkg::GPIO_PIO_OFFSET) begin
            rsp.rdata = 32'(ref_pio);
        end else if (req.addr[3:0] == sopc_pkg::GPIO_KEY_OFFSET) begin
            rsp.rdata = 32'(key);
        end
    end else begin
        rsp.err = 1'b1;     // Nothing mapped here.
    end
    return rsp;
endfunction

`endif

// ==== dv/sopc_fabric_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module sopc_fabric_tb;

    localparam int          RAM_ADDR_W = 12;
    localparam int          GPIO_W     = 4;
    localparam int          CLK_PERIOD = 20;
    localparam int          DRIVE_DLY  = 2;
    localparam int          PHASES     = 4;
    localparam int          XFERS      = 40;    // Per master and phase.
    localparam logic [31:0] SEED       = 32'h70040a74;

    logic               clk;
    logic               reset_i;
    logic               ibus_req_valid_i;
    sopc_pkg::bus_req_t ibus_req_i;
    logic               dbus_req_valid_i;
    sopc_pkg::bus_req_t dbus_req_i;
    logic [GPIO_W-1:0]  key_i;
    logic               ibus_req_ready_o;
    logic               ibus_rsp_valid_o;
    sopc_pkg::bus_rsp_t ibus_rsp_o;
    logic               dbus_req_ready_o;
    logic               dbus_rsp_valid_o;
    sopc_pkg::bus_rsp_t dbus_rsp_o;
    logic [GPIO_W-1:0]  pio_o;

    int                 xfer_count;
    int                 check_count;
    int                 data_errors;
    int                 proto_errors;
    logic [1:0]         pending;    // Outstanding transfer per port.
    logic               last_dbus;

    `include "sopc_model.svh"

    localparam int TOTAL_XFERS     = RAM_WINDOW_WORDS + PHASES * 2 * XFERS;
    localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 10 + 200;

    sopc_fabric #(
        .RAM_ADDR_W       (RAM_ADDR_W      ),
        .GPIO_W           (GPIO_W          )
    ) i_sopc_fabric (
        .clk              (clk             ),
        .reset_i          (reset_i         ),
        .ibus_req_valid_i (ibus_req_valid_i),
        .ibus_req_i       (ibus_req_i      ),
        .dbus_req_valid_i (dbus_req_valid_i),
        .dbus_req_i       (dbus_req_i      ),
        .key_i            (key_i           ),
        .ibus_req_ready_o (ibus_req_ready_o),
        .ibus_rsp_valid_o (ibus_rsp_valid_o),
        .ibus_rsp_o       (ibus_rsp_o      ),
        .dbus_req_ready_o (dbus_req_ready_o),
        .dbus_rsp_valid_o (dbus_rsp_valid_o),
        .dbus_rsp_o       (dbus_rsp_o      ),
        .pio_o            (pio_o           )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, transfers stopped completing.",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ##########################################################
    // Stimulus and checks
    // ##########################################################

    function automatic sopc_pkg::bus_req_t random_request();
        sopc_pkg::bus_req_t req;
        int unsigned        pick;
        pick      = $urandom_range(99);
        req.wr    = 1'($urandom_range(1));
        req.wdata = $urandom;
        req.strb  = 4'($urandom_range(15));
        if (pick < 65) begin
            req.addr = sopc_pkg::RAM_BASE + 32'($urandom_range(RAM_WINDOW_WORDS - 1) * 4);
            if (req.wr && req.strb == 4'h0) begin
                req.strb = 4'hF;    // The SRAM never accepts an empty strobe.
            end
        end else if (pick < 85) begin
            req.addr = sopc_pkg::GPIO_BASE + 32'($urandom_range(2) * 4); // Pio, key, spare.
        end else begin
            req.addr = {4'(2 + $urandom_range(13)), 28'($urandom)};
        end
        return req;
    endfunction

    task automatic drive_request(input bit use_dbus, input logic valid,
                                 input sopc_pkg::bus_req_t req);
        if (use_dbus) begin
            dbus_req_valid_i = valid;
            dbus_req_i       = req;
        end else begin
            ibus_req_valid_i = valid;
            ibus_req_i       = req;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            data_errors++;
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h at %0t",
                     name, got, exp, $time);
        end
    endtask

    task automatic issue_transfer(input bit use_dbus, input sopc_pkg::bus_req_t req);
        sopc_pkg::bus_rsp_t exp;
        sopc_pkg::bus_rsp_t got;
        logic [GPIO_W-1:0]  exp_pio;
        string              port;
        logic               seen;
        port = use_dbus ? "dbus" : "ibus";
        @(posedge clk);
        #DRIVE_DLY;
        drive_request(use_dbus, 1'b1, req);
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = use_dbus ? dbus_req_ready_o : ibus_req_ready_o;
        end
        exp     = apply_transfer(req, key_i);   // Handshake lands on the next edge.
        exp_pio = ref_pio;  // Pio as this transfer leaves it.
        xfer_count++;
        @(posedge clk);
        #DRIVE_DLY;
        drive_request(use_dbus, 1'b0, '0);
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = use_dbus ? dbus_rsp_valid_o : ibus_rsp_valid_o;
        end
        got = use_dbus ? dbus_rsp_o : ibus_rsp_o;
        check_value({port, " rsp.rdata"}, got.rdata, exp.rdata);
        check_value({port, " rsp.err"}, 32'(got.err), 32'(exp.err));
        check_value("pio_o", 32'(pio_o), 32'(exp_pio));
    endtask

    task automatic run_master(input bit use_dbus, input int count);
        for (int n = 0; n < count; n++) begin
            issue_transfer(use_dbus, random_request());
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(3, 1)) @(posedge clk);
            end
        end
    endtask

    task automatic track_port(input int idx, input logic ready, input logic rsp_valid);
        string port;
        port = (idx == 1) ? "dbus" : "ibus";
        if (rsp_valid) begin
            assert (pending[idx]) else begin
                proto_errors++;
                $display("Response on %s with no transfer outstanding at %0t.", port, $time);
            end
            pending[idx] = 1'b0;
        end
        if (ready) begin
            assert (!pending[idx]) else begin
                proto_errors++;
                $display("The %s port was accepted again before its response at %0t.",
                         port, $time);
            end
            pending[idx] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (reset_i) begin
            pending   = 2'b00;
            last_dbus = 1'b1;   // Instruction bus wins the first tie.
        end else begin
            track_port(0, ibus_req_ready_o, ibus_rsp_valid_o);
            track_port(1, dbus_req_ready_o, dbus_rsp_valid_o);
            if (ibus_req_valid_i && dbus_req_valid_i &&
                (ibus_req_ready_o || dbus_req_ready_o)) begin
                assert (dbus_req_ready_o != last_dbus) else begin
                    proto_errors++;
                    $display("Arbiter served the same master twice under contention at %0t.",
                             $time);
                end
            end
            if (ibus_req_ready_o || dbus_req_ready_o) begin
                last_dbus = dbus_req_ready_o;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset_i          = 1'b1;
        ibus_req_valid_i = 1'b0;
        ibus_req_i       = '0;
        dbus_req_valid_i = 1'b0;
        dbus_req_i       = '0;
        key_i            = '0;
        xfer_count       = 0;
        check_count      = 0;
        data_errors      = 0;
        proto_errors     = 0;
        ref_pio          = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("ibus_rsp_valid_o", 32'(ibus_rsp_valid_o), 32'h0);
        check_value("dbus_rsp_valid_o", 32'(dbus_rsp_valid_o), 32'h0);
        check_value("pio_o", 32'(pio_o), 32'h0);
        for (int w = 0; w < RAM_WINDOW_WORDS; w++) begin
            issue_transfer(1'b1, '{wr: 1'b1, addr: 32'(w * 4),
                                   wdata: fill_word(32'(w * 4)), strb: 4'hF});
        end
        for (int p = 0; p < PHASES; p++) begin
            @(posedge clk);
            #DRIVE_DLY;
            key_i = GPIO_W'($urandom);
            repeat (4) @(posedge clk);  // Key synchronizer settles.
            fork
                run_master(1'b0, XFERS);
                run_master(1'b1, XFERS);
            join
        end
        repeat (5) @(posedge clk);
        $display("Closing: %0d transfers, %0d checks, %0d data errors, %0d protocol errors",
                 xfer_count, check_count, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sopc_fabric.f ====
+incdir+dv
logic/sopc_pkg.sv
logic/bus_arbiter.sv
logic/slave_decoder.sv
logic/ram_bridge.sv
logic/sram.sv
logic/gpio_regs.sv
logic/sopc_fabric.sv
dv/sopc_fabric_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := sopc_fabric_tb
FILELIST  := sopc_fabric.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard logic/*.sv dv/*.sv dv/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure."; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended early."; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
